//--- list.f
+incdir+tests
design/rv_isa_pkg.sv
design/rv_core_pkg.sv
design/rv_decode.sv
design/rv_regfile.sv
design/rv_execute.sv
design/rv_result.sv
design/rv_core.sv
tests/tb_rv_core.sv

//--- tests/rv_core_vectors.svh
/* RV32I test program */
`ifndef RV_CORE_VECTORS_SVH
`define RV_CORE_VECTORS_SVH

// columns: instruction, expected next pc, rd write, rd, rd data, illegal
// entries run in program order from RESET_PC, idle slots carry no instruction

task automatic load_vectors();
    // reset state, nothing to retire
    idle_slot();
    idle_slot();

    // immediate ALU ops
    push_vector(op_imm(rv_isa_pkg::F3_ADD, 1, 0, 12'h123), 32'h80000004, 1, 1, 32'h123, 0);
    push_vector(op_imm(rv_isa_pkg::F3_ADD, 2, 0, -12'sd5), 32'h80000008, 1, 2, 32'hFFFFFFFB, 0);
    push_vector(op_imm(rv_isa_pkg::F3_SLT, 3, 2, -12'sd4), 32'h8000000C, 1, 3, 32'h1, 0);
    push_vector(op_imm(rv_isa_pkg::F3_SLTU, 4, 2, 12'd5), 32'h80000010, 1, 4, 32'h0, 0);
    push_vector(op_imm(rv_isa_pkg::F3_XOR, 5, 1, 12'h0F0), 32'h80000014, 1, 5, 32'h1D3, 0);
    push_vector(op_imm(rv_isa_pkg::F3_OR, 6, 1, 12'hF00), 32'h80000018, 1, 6, 32'hFFFFFF23, 0);
    push_vector(op_imm(rv_isa_pkg::F3_AND, 7, 2, 12'h07F), 32'h8000001C, 1, 7, 32'h7B, 0);
    push_vector(op_imm(rv_isa_pkg::F3_SLL, 8, 1, 12'h004), 32'h80000020, 1, 8, 32'h1230, 0);
    push_vector(op_imm(rv_isa_pkg::F3_SR, 9, 2, 12'h01C), 32'h80000024, 1, 9, 32'hF, 0);
    // SRAI has funct7 0100000 in the upper immediate bits
    push_vector(op_imm(rv_isa_pkg::F3_SR, 10, 2, 12'h401), 32'h80000028, 1, 10, 32'hFFFFFFFD, 0);

    // register ALU ops
    push_vector(reg_op(0, rv_isa_pkg::F3_ADD, 11, 1, 2), 32'h8000002C, 1, 11, 32'h11E, 0);
    push_vector(reg_op(1, rv_isa_pkg::F3_ADD, 12, 1, 2), 32'h80000030, 1, 12, 32'h128, 0);
    push_vector(reg_op(0, rv_isa_pkg::F3_SLL, 13, 1, 3), 32'h80000034, 1, 13, 32'h246, 0);
    push_vector(reg_op(0, rv_isa_pkg::F3_SLT, 14, 2, 1), 32'h80000038, 1, 14, 32'h1, 0);
    push_vector(reg_op(0, rv_isa_pkg::F3_SLTU, 15, 2, 1), 32'h8000003C, 1, 15, 32'h0, 0);
    push_vector(reg_op(0, rv_isa_pkg::F3_XOR, 16, 1, 2), 32'h80000040, 1, 16, 32'hFFFFFED8, 0);
    // shift amount 16 comes from the low bits of x8
    push_vector(reg_op(0, rv_isa_pkg::F3_SR, 17, 2, 8), 32'h80000044, 1, 17, 32'hFFFF, 0);
    push_vector(reg_op(1, rv_isa_pkg::F3_SR, 18, 2, 3), 32'h80000048, 1, 18, 32'hFFFFFFFD, 0);
    push_vector(reg_op(0, rv_isa_pkg::F3_OR, 19, 1, 7), 32'h8000004C, 1, 19, 32'h17B, 0);
    push_vector(reg_op(0, rv_isa_pkg::F3_AND, 20, 6, 5), 32'h80000050, 1, 20, 32'h103, 0);

    // upper immediates and x0
    push_vector(upper_imm(rv_isa_pkg::OPC_LUI, 21, 20'h12345),
                32'h80000054, 1, 21, 32'h12345000, 0);
    push_vector(upper_imm(rv_isa_pkg::OPC_AUIPC, 22, 20'h1),
                32'h80000058, 1, 22, 32'h80001054, 0);
    push_vector(op_imm(rv_isa_pkg::F3_ADD, 0, 1, 12'h055), 32'h8000005C, 0, 0, 32'h0, 0);
    push_vector(reg_op(0, rv_isa_pkg::F3_ADD, 23, 0, 0), 32'h80000060, 1, 23, 32'h0, 0);

    // branches, taken then not taken
    push_vector(branch_word(rv_isa_pkg::F3_BEQ, 3, 14, 13'd8), 32'h80000068, 0, 0, 32'h0, 0);
    push_vector(branch_word(rv_isa_pkg::F3_BEQ, 1, 2, 13'd8), 32'h8000006C, 0, 0, 32'h0, 0);
    push_vector(branch_word(rv_isa_pkg::F3_BNE, 1, 2, 13'd12), 32'h80000078, 0, 0, 32'h0, 0);
    push_vector(branch_word(rv_isa_pkg::F3_BNE, 3, 14, 13'd8), 32'h8000007C, 0, 0, 32'h0, 0);
    push_vector(branch_word(rv_isa_pkg::F3_BLT, 2, 1, 13'd16), 32'h8000008C, 0, 0, 32'h0, 0);
    push_vector(branch_word(rv_isa_pkg::F3_BLT, 1, 2, 13'd8), 32'h80000090, 0, 0, 32'h0, 0);
    push_vector(branch_word(rv_isa_pkg::F3_BGE, 1, 2, 13'd8), 32'h80000098, 0, 0, 32'h0, 0);
    push_vector(branch_word(rv_isa_pkg::F3_BGE, 2, 1, 13'd8), 32'h8000009C, 0, 0, 32'h0, 0);
    push_vector(branch_word(rv_isa_pkg::F3_BLTU, 1, 2, 13'd8), 32'h800000A4, 0, 0, 32'h0, 0);
    push_vector(branch_word(rv_isa_pkg::F3_BLTU, 2, 1, 13'd8), 32'h800000A8, 0, 0, 32'h0, 0);
    // backward target
    push_vector(branch_word(rv_isa_pkg::F3_BGEU, 2, 1, -13'sd40), 32'h80000080, 0, 0, 32'h0, 0);
    push_vector(branch_word(rv_isa_pkg::F3_BGEU, 1, 2, 13'd8), 32'h80000084, 0, 0, 32'h0, 0);

    // jumps, JALR sum is odd
    push_vector(jal_word(24, 21'h100), 32'h80000184, 1, 24, 32'h80000088, 0);
    push_vector(i_format(rv_isa_pkg::OPC_JALR, 3'b000, 25, 22, 12'h021),
                32'h80001074, 1, 25, 32'h80000188, 0);
    push_vector(jal_word(26, -21'sd116), 32'h80001000, 1, 26, 32'h80001078, 0);

    // load and CSR opcodes retire as illegal
    push_vector(i_format(7'b0000011, 3'b010, 27, 1, 12'h000), 32'h80001004, 0, 0, 32'h0, 1);
    push_vector(i_format(7'b1110011, 3'b001, 28, 1, 12'h300), 32'h80001008, 0, 0, 32'h0, 1);
    idle_slot();
    idle_slot();
    // x27 must still be zero after the load
    push_vector(op_imm(rv_isa_pkg::F3_ADD, 29, 27, 12'h007), 32'h8000100C, 1, 29, 32'h7, 0);
    idle_slot();
endtask

`endif

//--- tests/tb_rv_core.sv
/* RV32I core testbench */
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 10;

    typedef struct packed {
        logic [31:0] inst;
        logic        valid;
        logic [31:0] next_pc;
        logic        rd_we;
        logic [4:0]  rd;
        logic [31:0] rd_data;
        logic        illegal;
    } vector_t;

    logic                               clk;
    logic                               reset;
    logic [rv_core_pkg::XLEN-1:0]       inst;
    logic                               inst_valid;
    logic [rv_core_pkg::XLEN-1:0]       pc;
    logic                               retire_valid;
    logic [rv_core_pkg::XLEN-1:0]       retire_pc;
    logic [rv_core_pkg::XLEN-1:0]       retire_next_pc;
    logic                               retire_rd_we;
    logic [rv_core_pkg::REG_ADDR_W-1:0] retire_rd;
    logic [rv_core_pkg::XLEN-1:0]       retire_rd_data;
    logic                               retire_illegal;

    vector_t     vectors[$];
    vector_t     cur;
    vector_t     applied;
    logic [31:0] expect_pc;
    logic [31:0] entry_pc;
    int          table_len = 0;
    int          value_errors;
    int          retire_errors;

    rv_core dut_i (
        .clk,
        .reset,
        .inst,
        .inst_valid,
        .pc,
        .retire_valid,
        .retire_pc,
        .retire_next_pc,
        .retire_rd_we,
        .retire_rd,
        .retire_rd_data,
        .retire_illegal
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // instruction encoders
    function automatic logic [31:0] i_format(input logic [6:0] opcode, input logic [2:0] f3,
                                             input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [11:0] imm);
        return {imm, rs1, f3, rd, opcode};
    endfunction

    function automatic logic [31:0] op_imm(input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [11:0] imm);
        return i_format(rv_isa_pkg::OPC_OP_IMM, f3, rd, rs1, imm);
    endfunction

    function automatic logic [31:0] reg_op(input logic alt, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        logic [6:0] f7;
        f7 = alt ? rv_isa_pkg::F7_ALT : 7'b0; // alt picks SUB or SRA
        return {f7, rs2, rs1, f3, rd, rv_isa_pkg::OPC_OP};
    endfunction

    function automatic logic [31:0] upper_imm(input logic [6:0] opcode, input logic [4:0] rd,
                                              input logic [19:0] imm);
        return {imm, rd, opcode};
    endfunction

    function automatic logic [31:0] branch_word(input logic [2:0] f3, input logic [4:0] rs1,
                                                input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rv_isa_pkg::OPC_BRANCH};
    endfunction

    function automatic logic [31:0] jal_word(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, rv_isa_pkg::OPC_JAL};
    endfunction

    task automatic push_vector(input logic [31:0] word, input logic [31:0] next_pc,
                               input logic rd_we, input logic [4:0] rd,
                               input logic [31:0] rd_data, input logic illegal);
        vector_t v;
        v.inst    = word;
        v.valid   = 1'b1;
        v.next_pc = next_pc;
        v.rd_we   = rd_we;
        v.rd      = rd;
        v.rd_data = rd_data;
        v.illegal = illegal;
        vectors.push_back(v);
    endtask

    task automatic idle_slot();
        vector_t v;
        v = '0;
        vectors.push_back(v);
    endtask

    `include "rv_core_vectors.svh"

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual, input logic [31:0] at_pc);
        $display("** Error: %s expected %h, got %h (pc %h)", name, expected, actual, at_pc);
        value_errors++;
    endtask

    task automatic check_retire(input vector_t v, input logic [31:0] v_pc);
        if (v.valid) begin
            if (retire_valid !== 1'b1) begin
                $display("no retire for instruction %h at pc %h", v.inst, v_pc);
                retire_errors++;
            end else begin
                if (retire_pc !== v_pc)
                    report_mismatch("retire_pc", v_pc, retire_pc, v_pc);
                if (retire_next_pc !== v.next_pc)
                    report_mismatch("retire_next_pc", v.next_pc, retire_next_pc, v_pc);
                if (retire_rd_we !== v.rd_we)
                    report_mismatch("retire_rd_we", v.rd_we, retire_rd_we, v_pc);
                if (retire_illegal !== v.illegal)
                    report_mismatch("retire_illegal", v.illegal, retire_illegal, v_pc);
                // rd and its data only mean something on a write
                if (v.rd_we && retire_rd !== v.rd)
                    report_mismatch("retire_rd", v.rd, retire_rd, v_pc);
                if (v.rd_we && retire_rd_data !== v.rd_data)
                    report_mismatch("retire_rd_data", v.rd_data, retire_rd_data, v_pc);
            end
        end else if (retire_valid !== 1'b0) begin
            $display("retire seen after an idle cycle, retire_pc %h", retire_pc);
            retire_errors++;
        end
    endtask

    initial begin
        clk           = 1'b0;
        reset         = 1'b1;
        inst          = '0;
        inst_valid    = 1'b0;
        value_errors  = 0;
        retire_errors = 0;
        applied       = '0;
        load_vectors();
        table_len = vectors.size();
        repeat (RESET_CYCLES) @(negedge clk);
        reset     = 1'b0;
        expect_pc = rv_core_pkg::RESET_PC;
        entry_pc  = expect_pc;
        for (int i = 0; i <= table_len; i++) begin
            @(negedge clk);
            if (i > 0)
                check_retire(applied, entry_pc); // entry from the previous cycle
            if (pc !== expect_pc)
                report_mismatch("pc", expect_pc, pc, expect_pc);
            if (i < table_len) begin
                cur        = vectors[i];
                inst       = cur.inst;
                inst_valid = cur.valid;
                applied    = cur;
                entry_pc   = expect_pc;
                if (cur.valid)
                    expect_pc = cur.next_pc;
            end else begin
                inst       = '0;
                inst_valid = 1'b0;
            end
        end
        $display("errors: %0d wrong values, %0d retire mismatches", value_errors, retire_errors);
        if (value_errors + retire_errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

    // watchdog
    initial begin
        wait (table_len > 0);
        #((table_len + 20) * CLK_PERIOD);
        $display("timeout: the test did not finish within %0d cycles", table_len + 20);
        $display("errors: %0d wrong values, %0d retire mismatches", value_errors, retire_errors);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- design/rv_core.sv
/* RV32I core top */
`timescale 1ns/1ps
`default_nettype none

module rv_core (
    input  wire                                 clk,
    input  wire                                 reset,
    input  wire  [rv_core_pkg::XLEN-1:0]       inst,
    input  wire                                 inst_valid,
    output logic [rv_core_pkg::XLEN-1:0]       pc,
    output logic                                retire_valid,
    output logic [rv_core_pkg::XLEN-1:0]       retire_pc,
    output logic [rv_core_pkg::XLEN-1:0]       retire_next_pc,
    output logic                                retire_rd_we,
    output logic [rv_core_pkg::REG_ADDR_W-1:0] retire_rd,
    output logic [rv_core_pkg::XLEN-1:0]       retire_rd_data,
    output logic                                retire_illegal
);

    logic [rv_core_pkg::REG_ADDR_W-1:0] rs1_addr;
    logic [rv_core_pkg::REG_ADDR_W-1:0] rs2_addr;
    logic [rv_core_pkg::REG_ADDR_W-1:0] rd;
    logic [rv_core_pkg::XLEN-1:0]       imm;
    logic [rv_core_pkg::XLEN-1:0]       rs1_data;
    logic [rv_core_pkg::XLEN-1:0]       rs2_data;
    logic [rv_core_pkg::XLEN-1:0]       alu_result;
    logic [rv_core_pkg::XLEN-1:0]       next_pc;
    logic [rv_core_pkg::XLEN-1:0]       rd_data;
    logic                               rd_we;
    logic                               illegal;
    rv_core_pkg::alu_op_t               alu_op;
    rv_core_pkg::op_a_sel_t             op_a_sel;
    rv_core_pkg::op_b_sel_t             op_b_sel;
    rv_core_pkg::branch_cond_t          branch_cond;
    rv_core_pkg::wb_sel_t               wb_sel;

    rv_decode decode_i (
        .inst,
        .rs1_addr,
        .rs2_addr,
        .rd,
        .imm,
        .alu_op,
        .op_a_sel,
        .op_b_sel,
        .branch_cond,
        .wb_sel,
        .illegal
    );

    rv_regfile regfile_i (
        .clk,
        .reset,
        .rs1_addr,
        .rs2_addr,
        .rd_we,
        .rd,
        .rd_data,
        .rs1_data,
        .rs2_data
    );

    rv_execute execute_i (
        .pc,
        .rs1_data,
        .rs2_data,
        .imm,
        .alu_op,
        .op_a_sel,
        .op_b_sel,
        .branch_cond,
        .alu_result,
        .next_pc
    );

    rv_result result_i (
        .clk,
        .reset,
        .inst_valid,
        .rd,
        .wb_sel,
        .illegal,
        .alu_result,
        .next_pc,
        .pc,
        .rd_we,
        .rd_data,
        .retire_valid,
        .retire_pc,
        .retire_next_pc,
        .retire_rd_we,
        .retire_rd,
        .retire_rd_data,
        .retire_illegal
    );

endmodule

`default_nettype wire

//--- design/rv_result.sv
/* write-back, pc and retire record */
`timescale 1ns/1ps
`default_nettype none

module rv_result (
    input  wire                                 clk,
    input  wire                                 reset,
    input  wire                                 inst_valid,
    input  wire  [rv_core_pkg::REG_ADDR_W-1:0] rd,
    input  wire  rv_core_pkg::wb_sel_t          wb_sel,
    input  wire                                 illegal,
    input  wire  [rv_core_pkg::XLEN-1:0]       alu_result,
    input  wire  [rv_core_pkg::XLEN-1:0]       next_pc,
    output logic [rv_core_pkg::XLEN-1:0]       pc,
    output logic                                rd_we,
    output logic [rv_core_pkg::XLEN-1:0]       rd_data,
    output logic                                retire_valid,
    output logic [rv_core_pkg::XLEN-1:0]       retire_pc,
    output logic [rv_core_pkg::XLEN-1:0]       retire_next_pc,
    output logic                                retire_rd_we,
    output logic [rv_core_pkg::REG_ADDR_W-1:0] retire_rd,
    output logic [rv_core_pkg::XLEN-1:0]       retire_rd_data,
    output logic                                retire_illegal
);

    assign rd_data = (wb_sel == rv_core_pkg::WB_LINK) ? pc + rv_core_pkg::INST_BYTES
                                                      : alu_result;
    assign rd_we   = inst_valid && (wb_sel != rv_core_pkg::WB_NONE);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc             <= rv_core_pkg::RESET_PC;
            retire_valid   <= 1'b0;
            retire_rd_we   <= 1'b0;
            retire_illegal <= 1'b0;
        end else begin
            retire_valid <= inst_valid;
            retire_rd_we <= rd_we; // already qualified by inst_valid
            if (inst_valid) begin
                pc             <= next_pc;
                retire_illegal <= illegal;
            end
        end
    end

    // retire payload
    always_ff @(posedge clk) begin
        if (inst_valid) begin
            retire_pc      <= pc;
            retire_next_pc <= next_pc;
            retire_rd      <= rd;
            retire_rd_data <= rd_data;
        end
    end

    // one retire per accepted instruction, exactly one cycle later
    a_retire_timing: assert property (
        @(posedge clk) disable iff (reset) retire_valid == $past(inst_valid)
    );

endmodule

`default_nettype wire

//--- design/rv_execute.sv
/* ALU and next pc */
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
    input  wire  [rv_core_pkg::XLEN-1:0] pc,
    input  wire  [rv_core_pkg::XLEN-1:0] rs1_data,
    input  wire  [rv_core_pkg::XLEN-1:0] rs2_data,
    input  wire  [rv_core_pkg::XLEN-1:0] imm,
    input  wire  rv_core_pkg::alu_op_t      alu_op,
    input  wire  rv_core_pkg::op_a_sel_t    op_a_sel,
    input  wire  rv_core_pkg::op_b_sel_t    op_b_sel,
    input  wire  rv_core_pkg::branch_cond_t branch_cond,
    output logic [rv_core_pkg::XLEN-1:0] alu_result,
    output logic [rv_core_pkg::XLEN-1:0] next_pc
);

    logic [rv_core_pkg::XLEN-1:0]    op_a;
    logic [rv_core_pkg::XLEN-1:0]    op_b;
    logic [rv_core_pkg::SHAMT_W-1:0] shamt;
    logic [rv_core_pkg::XLEN-1:0]    jump_target;
    logic                            taken;

    always_comb begin
        case (op_a_sel)
            rv_core_pkg::OP_A_RS1: op_a = rs1_data;
            rv_core_pkg::OP_A_PC:  op_a = pc;
            default:               op_a = '0; // LUI
        endcase
    end

    assign op_b  = (op_b_sel == rv_core_pkg::OP_B_IMM) ? imm : rs2_data;
    assign shamt = op_b[rv_core_pkg::SHAMT_W-1:0];

    always_comb begin
        case (alu_op)
            rv_core_pkg::ALU_ADD:  alu_result = op_a + op_b;
            rv_core_pkg::ALU_SUB:  alu_result = op_a - op_b;
            rv_core_pkg::ALU_SLL:  alu_result = op_a << shamt;
            rv_core_pkg::ALU_SLT: begin
                alu_result = {{(rv_core_pkg::XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            end
            rv_core_pkg::ALU_SLTU: begin
                alu_result = {{(rv_core_pkg::XLEN-1){1'b0}}, op_a < op_b};
            end
            rv_core_pkg::ALU_XOR:  alu_result = op_a ^ op_b;
            rv_core_pkg::ALU_SRL:  alu_result = op_a >> shamt;
            rv_core_pkg::ALU_SRA:  alu_result = $signed(op_a) >>> shamt;
            rv_core_pkg::ALU_OR:   alu_result = op_a | op_b;
            default:               alu_result = op_a & op_b;
        endcase
    end

    // branch compare always works on the register operands
    always_comb begin
        case (branch_cond)
            rv_core_pkg::BR_ALWAYS: taken = 1'b1;
            rv_core_pkg::BR_EQ:     taken = (rs1_data == rs2_data);
            rv_core_pkg::BR_NE:     taken = (rs1_data != rs2_data);
            rv_core_pkg::BR_LT:     taken = ($signed(rs1_data) < $signed(rs2_data));
            rv_core_pkg::BR_GE:     taken = ($signed(rs1_data) >= $signed(rs2_data));
            rv_core_pkg::BR_LTU:    taken = (rs1_data < rs2_data);
            rv_core_pkg::BR_GEU:    taken = (rs1_data >= rs2_data);
            default:                taken = 1'b0;
        endcase
    end

    // bit 0 matters only for JALR, pc + imm is already even
    assign jump_target = {alu_result[rv_core_pkg::XLEN-1:1], 1'b0};
    assign next_pc     = taken ? jump_target : pc + rv_core_pkg::INST_BYTES;

endmodule

`default_nettype wire

//--- design/rv_regfile.sv
/* integer register file */
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
    input  wire                                 clk,
    input  wire                                 reset,
    input  wire  [rv_core_pkg::REG_ADDR_W-1:0] rs1_addr,
    input  wire  [rv_core_pkg::REG_ADDR_W-1:0] rs2_addr,
    input  wire                                 rd_we,
    input  wire  [rv_core_pkg::REG_ADDR_W-1:0] rd,
    input  wire  [rv_core_pkg::XLEN-1:0]       rd_data,
    output logic [rv_core_pkg::XLEN-1:0]       rs1_data,
    output logic [rv_core_pkg::XLEN-1:0]       rs2_data
);

    logic [rv_core_pkg::XLEN-1:0] regs [rv_core_pkg::NUM_REGS];

    // x0 stays zero since decode never writes it
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < rv_core_pkg::NUM_REGS; i++)
                regs[i] <= '0;
        end else if (rd_we) begin
            regs[rd] <= rd_data;
        end
    end

    // reads see the value before this edge's write
    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

    // decode must drop every write aimed at x0
    a_no_x0_write: assert property (
        @(posedge clk) disable iff (reset) rd_we |-> (rd != '0)
    );

endmodule

`default_nettype wire

//--- design/rv_decode.sv
/* instruction decode */
`timescale 1ns/1ps
`default_nettype none

module rv_decode (
    input  wire  [rv_core_pkg::XLEN-1:0]       inst,
    output logic [rv_core_pkg::REG_ADDR_W-1:0] rs1_addr,
    output logic [rv_core_pkg::REG_ADDR_W-1:0] rs2_addr,
    output logic [rv_core_pkg::REG_ADDR_W-1:0] rd,
    output logic [rv_core_pkg::XLEN-1:0]       imm,
    output rv_core_pkg::alu_op_t               alu_op,
    output rv_core_pkg::op_a_sel_t             op_a_sel,
    output rv_core_pkg::op_b_sel_t             op_b_sel,
    output rv_core_pkg::branch_cond_t          branch_cond,
    output rv_core_pkg::wb_sel_t               wb_sel,
    output logic                               illegal
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    rv_isa_pkg::inst_type_t inst_type;

    assign opcode   = inst[6:0];
    assign funct3   = inst[rv_isa_pkg::F3_LSB +: 3];
    assign funct7   = inst[rv_isa_pkg::F7_LSB +: 7];
    assign rd       = inst[rv_isa_pkg::RD_LSB +: rv_core_pkg::REG_ADDR_W];
    assign rs1_addr = inst[rv_isa_pkg::RS1_LSB +: rv_core_pkg::REG_ADDR_W];
    assign rs2_addr = inst[rv_isa_pkg::RS2_LSB +: rv_core_pkg::REG_ADDR_W];

    always_comb begin
        case (opcode)
            rv_isa_pkg::OPC_OP:                        inst_type = rv_isa_pkg::TYPE_R;
            rv_isa_pkg::OPC_OP_IMM, rv_isa_pkg::OPC_JALR: inst_type = rv_isa_pkg::TYPE_I;
            rv_isa_pkg::OPC_LUI, rv_isa_pkg::OPC_AUIPC: inst_type = rv_isa_pkg::TYPE_U;
            rv_isa_pkg::OPC_JAL:                       inst_type = rv_isa_pkg::TYPE_J;
            rv_isa_pkg::OPC_BRANCH:                    inst_type = rv_isa_pkg::TYPE_B;
            default:                                   inst_type = rv_isa_pkg::TYPE_N;
        endcase
    end

    // sign-extended immediate per format
    always_comb begin
        case (inst_type)
            rv_isa_pkg::TYPE_I: imm = {{20{inst[31]}}, inst[31:20]};
            rv_isa_pkg::TYPE_U: imm = {inst[31:12], 12'b0};
            rv_isa_pkg::TYPE_J: imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            rv_isa_pkg::TYPE_B: imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            default:            imm = '0;
        endcase
    end

    always_comb begin
        alu_op = rv_core_pkg::ALU_ADD; // address sums use ADD
        if (inst_type == rv_isa_pkg::TYPE_R || opcode == rv_isa_pkg::OPC_OP_IMM) begin
            case (funct3)
                rv_isa_pkg::F3_ADD: begin
                    if (inst_type == rv_isa_pkg::TYPE_R && funct7 == rv_isa_pkg::F7_ALT)
                        alu_op = rv_core_pkg::ALU_SUB;
                end
                rv_isa_pkg::F3_SLL:  alu_op = rv_core_pkg::ALU_SLL;
                rv_isa_pkg::F3_SLT:  alu_op = rv_core_pkg::ALU_SLT;
                rv_isa_pkg::F3_SLTU: alu_op = rv_core_pkg::ALU_SLTU;
                rv_isa_pkg::F3_XOR:  alu_op = rv_core_pkg::ALU_XOR;
                rv_isa_pkg::F3_SR: begin
                    alu_op = (funct7 == rv_isa_pkg::F7_ALT) ? rv_core_pkg::ALU_SRA
                                                             : rv_core_pkg::ALU_SRL;
                end
                rv_isa_pkg::F3_OR:   alu_op = rv_core_pkg::ALU_OR;
                default:             alu_op = rv_core_pkg::ALU_AND;
            endcase
        end
    end

    always_comb begin
        op_a_sel    = rv_core_pkg::OP_A_RS1;
        op_b_sel    = rv_core_pkg::OP_B_IMM;
        branch_cond = rv_core_pkg::BR_NEVER;
        wb_sel      = rv_core_pkg::WB_ALU;
        illegal     = 1'b0;
        case (inst_type)
            rv_isa_pkg::TYPE_R: op_b_sel = rv_core_pkg::OP_B_RS2;
            rv_isa_pkg::TYPE_I: begin
                if (opcode == rv_isa_pkg::OPC_JALR) begin
                    branch_cond = rv_core_pkg::BR_ALWAYS;
                    wb_sel      = rv_core_pkg::WB_LINK;
                end
            end
            rv_isa_pkg::TYPE_U: begin
                op_a_sel = (opcode == rv_isa_pkg::OPC_LUI) ? rv_core_pkg::OP_A_ZERO
                                                           : rv_core_pkg::OP_A_PC;
            end
            rv_isa_pkg::TYPE_J: begin
                op_a_sel    = rv_core_pkg::OP_A_PC;
                branch_cond = rv_core_pkg::BR_ALWAYS;
                wb_sel      = rv_core_pkg::WB_LINK;
            end
            rv_isa_pkg::TYPE_B: begin
                op_a_sel = rv_core_pkg::OP_A_PC; // target is pc + imm
                wb_sel   = rv_core_pkg::WB_NONE;
                case (funct3)
                    rv_isa_pkg::F3_BEQ:  branch_cond = rv_core_pkg::BR_EQ;
                    rv_isa_pkg::F3_BNE:  branch_cond = rv_core_pkg::BR_NE;
                    rv_isa_pkg::F3_BLT:  branch_cond = rv_core_pkg::BR_LT;
                    rv_isa_pkg::F3_BGE:  branch_cond = rv_core_pkg::BR_GE;
                    rv_isa_pkg::F3_BLTU: branch_cond = rv_core_pkg::BR_LTU;
                    rv_isa_pkg::F3_BGEU: branch_cond = rv_core_pkg::BR_GEU;
                    default:             branch_cond = rv_core_pkg::BR_NEVER;
                endcase
            end
            default: begin
                wb_sel  = rv_core_pkg::WB_NONE; // retires as a no-op
                illegal = 1'b1;
            end
        endcase
        if (rd == '0)
            wb_sel = rv_core_pkg::WB_NONE;
    end

    // a clean instruction word always lands on a known format
    always_comb begin
        if (!$isunknown(inst))
            a_type_known: assert final (!$isunknown(inst_type));
    end

endmodule

`default_nettype wire

//--- design/rv_core_pkg.sv
/* core widths and control encodings */
`default_nettype none

package rv_core_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    localparam int SHAMT_W    = 5;

    localparam logic [XLEN-1:0] RESET_PC   = 32'h8000_0000;
    localparam logic [XLEN-1:0] INST_BYTES = 32'd4; // sequential pc step

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    typedef enum logic [1:0] {OP_A_RS1, OP_A_PC, OP_A_ZERO} op_a_sel_t;

    typedef enum logic {OP_B_RS2, OP_B_IMM} op_b_sel_t;

    typedef enum logic [2:0] {
        BR_NEVER,
        BR_ALWAYS, // JAL, JALR
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_LTU,
        BR_GEU
    } branch_cond_t;

    typedef enum logic [1:0] {WB_NONE, WB_ALU, WB_LINK} wb_sel_t;

endpackage

`default_nettype wire

//--- design/rv_isa_pkg.sv
/* RV32I instruction encodings */
`default_nettype none

package rv_isa_pkg;

    // major opcodes, inst[6:0]
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // field positions
    localparam int RD_LSB  = 7;
    localparam int F3_LSB  = 12;
    localparam int RS1_LSB = 15;
    localparam int RS2_LSB = 20;
    localparam int F7_LSB  = 25;

    // funct3 for ALU ops
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101; // SRL or SRA by funct7
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // funct3 for branches
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [6:0] F7_ALT = 7'b0100000; // SUB, SRA

    typedef enum logic [2:0] {
        TYPE_R,
        TYPE_I,
        TYPE_U,
        TYPE_J,
        TYPE_B,
        TYPE_N  // no supported format
    } inst_type_t;

endpackage

`default_nettype wire
